//--- rtl/icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// cache geometry
`define ICACHE_OFFSET_W 4
`define ICACHE_INDEX_W 2
`define ICACHE_TAG_W (32 - `ICACHE_OFFSET_W - `ICACHE_INDEX_W)

// words per line
`define ICACHE_WORDS (1 << (`ICACHE_OFFSET_W - 2))

// word address bits of the backing ram where upper bits alias
`define MEM_ADDR_W 10

// cycles from address handshake to first beat
`define MEM_LATENCY 3

`endif

//--- rtl/icache_pkg.sv
`default_nettype none

package icache_pkg;

  typedef struct packed {
    logic [31:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic [31:0] data;
  } fetch_resp_t;

  typedef enum logic [0:0] {
    BURST_INCR,
    BURST_WRAP
  } burst_e;

  typedef struct packed {
    logic [31:0] addr;
    logic [7:0]  len;   // beats minus one
    burst_e      burst;
  } mem_ar_t;

  typedef struct packed {
    logic [31:0] data;
    logic        last;
  } mem_r_t;

  typedef struct packed {
    logic [31:0] addr;  // byte address
    logic [31:0] data;
  } mem_wr_t;

  typedef enum logic [1:0] {
    CS_IDLE,
    CS_HIT_RESP,
    CS_REFILL
  } cache_state_e;

  typedef enum logic [1:0] {
    MS_IDLE,
    MS_WAIT,
    MS_BEAT
  } mem_state_e;

endpackage

`default_nettype wire

//--- rtl/icache_perf.sv
`timescale 1ns/10ps
`default_nettype none

module icache_perf (
  input  logic        clk,
  input  logic        rstn,
  input  logic        hit_evt,
  input  logic        miss_evt,
  output logic [31:0] hit_count,
  output logic [31:0] miss_count
);

  logic [31:0] hit_q;
  logic [31:0] miss_q;

  // saturating counters stick at all ones
  always_ff @(posedge clk) begin
    if (!rstn) begin
      hit_q  <= '0;
      miss_q <= '0;
    end else begin
      if (hit_evt && hit_q != '1) hit_q <= hit_q + 32'd1;
      if (miss_evt && miss_q != '1) miss_q <= miss_q + 32'd1;
    end
  end

  assign hit_count  = hit_q;
  assign miss_count = miss_q;

  one_event_a: assert property (@(posedge clk) disable iff (!rstn)
    !(hit_evt && miss_evt))
    else $error("hit and miss reported for the same access");

endmodule

`default_nettype wire

//--- rtl/burst_ram.sv
`timescale 1ns/10ps
`default_nettype none
`include "icache_settings.svh"

module burst_ram (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 mem_ar_valid,
  input  icache_pkg::mem_ar_t  mem_ar,
  output logic                 mem_ar_ready,
  output logic                 mem_r_valid,
  output icache_pkg::mem_r_t   mem_r,
  input  logic                 mem_r_ready,
  input  logic                 mem_wr_valid,
  input  icache_pkg::mem_wr_t  mem_wr
);

  localparam int ADDR_W  = `MEM_ADDR_W;
  localparam int DEPTH   = 1 << ADDR_W;
  localparam int LATENCY = `MEM_LATENCY;

  logic [31:0] mem_q [DEPTH];

  icache_pkg::mem_state_e state_q;
  icache_pkg::burst_e     burst_q;
  icache_pkg::mem_r_t     r_q;

  logic [7:0]  cnt_q;
  logic [7:0]  beats_left_q;
  logic [7:0]  len_q;
  logic [31:0] addr_q;       // address of the next beat to read
  logic        ar_fire;
  logic        load_beat;

  // next beat address with wrap inside the aligned block
  function automatic logic [31:0] next_addr(input logic [31:0] a,
                                            input logic [7:0] len,
                                            input icache_pkg::burst_e kind);
    logic [31:0] span;
    logic [31:0] incr;
    span = ({24'd0, len} + 32'd1) << 2;
    incr = a + 32'd4;
    if (kind == icache_pkg::BURST_WRAP) return (a & ~(span - 32'd1)) | (incr & (span - 32'd1));
    return incr;
  endfunction

  assign mem_ar_ready = (state_q == icache_pkg::MS_IDLE);
  assign ar_fire      = mem_ar_valid && mem_ar_ready;
  assign load_beat    = (state_q == icache_pkg::MS_WAIT && cnt_q == 8'd1)
                     || (state_q == icache_pkg::MS_BEAT && mem_r_ready && !r_q.last);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state_q      <= icache_pkg::MS_IDLE;
      cnt_q        <= '0;
      beats_left_q <= '0;
    end else begin
      if (load_beat) beats_left_q <= beats_left_q - 8'd1;
      case (state_q)
        icache_pkg::MS_IDLE: begin
          if (ar_fire) begin
            cnt_q        <= 8'(LATENCY);
            beats_left_q <= mem_ar.len;
            state_q      <= icache_pkg::MS_WAIT;
          end
        end
        icache_pkg::MS_WAIT: begin
          if (cnt_q == 8'd1) state_q <= icache_pkg::MS_BEAT;
          else cnt_q <= cnt_q - 8'd1;
        end
        icache_pkg::MS_BEAT: begin
          if (mem_r_ready && r_q.last) state_q <= icache_pkg::MS_IDLE;
        end
        default: state_q <= icache_pkg::MS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      addr_q  <= mem_ar.addr;
      len_q   <= mem_ar.len;
      burst_q <= mem_ar.burst;
    end
    if (load_beat) begin
      r_q.data <= mem_q[addr_q[ADDR_W+1:2]];
      r_q.last <= (beats_left_q == 8'd0);
      addr_q   <= next_addr(addr_q, len_q, burst_q);
    end
  end

  // load port writes bypass the cache
  always_ff @(posedge clk) begin
    if (mem_wr_valid) mem_q[mem_wr.addr[ADDR_W+1:2]] <= mem_wr.data;
  end

  assign mem_r_valid = (state_q == icache_pkg::MS_BEAT);
  assign mem_r       = r_q;

  wrap_pow2_a: assert property (@(posedge clk) disable iff (!rstn)
    mem_ar_valid && mem_ar.burst == icache_pkg::BURST_WRAP
      |-> (({1'b0, mem_ar.len} + 9'd1) & {1'b0, mem_ar.len}) == 9'd0)
    else $error("wrap burst length is not a power of two");

  word_aligned_a: assert property (@(posedge clk) disable iff (!rstn)
    mem_ar_valid |-> mem_ar.addr[1:0] == 2'b00)
    else $error("burst start address not word aligned");

endmodule

`default_nettype wire

//--- rtl/icache.sv
`timescale 1ns/10ps
`default_nettype none
`include "icache_settings.svh"

module icache (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     fetch_req_valid,
  input  icache_pkg::fetch_req_t   fetch_req,
  output logic                     fetch_req_ready,
  output logic                     fetch_resp_valid,
  output icache_pkg::fetch_resp_t  fetch_resp,
  input  logic                     fetch_resp_ready,
  input  logic                     flush,
  output logic                     mem_ar_valid,
  output icache_pkg::mem_ar_t      mem_ar,
  input  logic                     mem_ar_ready,
  input  logic                     mem_r_valid,
  input  icache_pkg::mem_r_t       mem_r,
  output logic                     mem_r_ready,
  output logic                     hit_evt,
  output logic                     miss_evt
);

  localparam int OFFSET_W = `ICACHE_OFFSET_W;
  localparam int INDEX_W  = `ICACHE_INDEX_W;
  localparam int TAG_W    = `ICACHE_TAG_W;
  localparam int WORDS    = `ICACHE_WORDS;
  localparam int WOFF_W   = OFFSET_W - 2;
  localparam int LINES    = 1 << INDEX_W;

  logic [LINES-1:0] valid_q;
  logic [TAG_W-1:0] tag_mem [LINES];
  logic [31:0]      data_mem [LINES][WORDS];

  icache_pkg::cache_state_e state_q;
  icache_pkg::fetch_resp_t  resp_q;

  logic [TAG_W-1:0]   req_tag_q;
  logic [INDEX_W-1:0] req_index_q;
  logic [WOFF_W-1:0]  req_word_q;
  logic [WOFF_W-1:0]  fill_off_q;
  logic               owed_q;        // response not yet taken by fetch port
  logic               flush_pend_q;
  logic               ar_valid_q;
  logic               resp_valid_q;
  logic               hit_evt_q;
  logic               miss_evt_q;

  logic [TAG_W-1:0]   in_tag;
  logic [INDEX_W-1:0] in_index;
  logic [WOFF_W-1:0]  in_word;
  logic               in_hit;
  logic               accept;
  logic               ar_fire;
  logic               beat_fire;
  logic               first_beat;
  logic               fill_last;
  logic               resp_fire;
  logic               owed_after;

  assign in_tag   = fetch_req.addr[31 -: TAG_W];
  assign in_index = fetch_req.addr[OFFSET_W +: INDEX_W];
  assign in_word  = fetch_req.addr[2 +: WOFF_W];
  assign in_hit   = valid_q[in_index] && (tag_mem[in_index] == in_tag);

  assign fetch_req_ready = (state_q == icache_pkg::CS_IDLE);
  assign accept          = fetch_req_valid && fetch_req_ready;
  assign ar_fire         = ar_valid_q && mem_ar_ready;
  assign beat_fire       = mem_r_valid && mem_r_ready;
  assign first_beat      = beat_fire && owed_q && !resp_valid_q; // critical word
  assign fill_last       = beat_fire && mem_r.last;
  assign resp_fire       = resp_valid_q && fetch_resp_ready;
  assign owed_after      = owed_q && !resp_fire;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state_q      <= icache_pkg::CS_IDLE;
      ar_valid_q   <= 1'b0;
      resp_valid_q <= 1'b0;
      owed_q       <= 1'b0;
      flush_pend_q <= 1'b0;
      hit_evt_q    <= 1'b0;
      miss_evt_q   <= 1'b0;
      fill_off_q   <= '0;
    end else begin
      hit_evt_q  <= accept && in_hit;
      miss_evt_q <= accept && !in_hit;
      if (ar_fire) ar_valid_q <= 1'b0;
      if (resp_fire) begin
        resp_valid_q <= 1'b0;
        owed_q       <= 1'b0;
      end
      if (beat_fire) fill_off_q <= fill_off_q + 1'b1; // wraps within line
      if (first_beat) resp_valid_q <= 1'b1;
      case (state_q)
        icache_pkg::CS_IDLE: begin
          if (accept && in_hit) begin
            resp_valid_q <= 1'b1;
            state_q      <= icache_pkg::CS_HIT_RESP;
          end else if (accept) begin
            ar_valid_q <= 1'b1;
            owed_q     <= 1'b1;
            fill_off_q <= in_word; // burst starts at requested word
            state_q    <= icache_pkg::CS_REFILL;
          end
        end
        icache_pkg::CS_HIT_RESP: begin
          if (resp_fire) state_q <= icache_pkg::CS_IDLE;
        end
        icache_pkg::CS_REFILL: begin
          if (flush) flush_pend_q <= 1'b1;
          if (fill_last) begin
            flush_pend_q <= 1'b0;
            state_q      <= owed_after ? icache_pkg::CS_HIT_RESP : icache_pkg::CS_IDLE;
          end
        end
        default: state_q <= icache_pkg::CS_IDLE;
      endcase
    end
  end

  // flush during refill lands at fill end
  always_ff @(posedge clk) begin
    if (!rstn) begin
      valid_q <= '0;
    end else if (flush && state_q != icache_pkg::CS_REFILL) begin
      valid_q <= '0;
    end else if (fill_last) begin
      if (flush || flush_pend_q) valid_q <= '0;
      else valid_q[req_index_q] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_tag_q   <= in_tag;
      req_index_q <= in_index;
      req_word_q  <= in_word;
      if (in_hit) resp_q.data <= data_mem[in_index][in_word];
    end
    if (beat_fire) data_mem[req_index_q][fill_off_q] <= mem_r.data;
    if (first_beat) resp_q.data <= mem_r.data;
    if (fill_last) tag_mem[req_index_q] <= req_tag_q;
  end

  always_comb begin
    mem_ar.addr  = {req_tag_q, req_index_q, req_word_q, 2'b00};
    mem_ar.len   = 8'(WORDS - 1);
    mem_ar.burst = icache_pkg::BURST_WRAP;
  end

  assign mem_ar_valid     = ar_valid_q;
  assign mem_r_ready      = 1'b1; // line store always takes a beat
  assign fetch_resp_valid = resp_valid_q;
  assign fetch_resp       = resp_q;
  assign hit_evt          = hit_evt_q;
  assign miss_evt         = miss_evt_q;

  ar_stable_a: assert property (@(posedge clk) disable iff (!rstn)
    mem_ar_valid && !mem_ar_ready |=> mem_ar_valid && $stable(mem_ar))
    else $error("mem_ar dropped or changed before handshake");

  resp_stable_a: assert property (@(posedge clk) disable iff (!rstn)
    fetch_resp_valid && !fetch_resp_ready |=> fetch_resp_valid && $stable(fetch_resp))
    else $error("fetch_resp dropped or changed before handshake");

  no_idle_beat_a: assert property (@(posedge clk) disable iff (!rstn)
    mem_r_valid |-> state_q != icache_pkg::CS_IDLE)
    else $error("read beat arrived with no refill in progress");

endmodule

`default_nettype wire

//--- rtl/icache_sys_top.sv
`timescale 1ns/10ps
`default_nettype none

module icache_sys_top (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     fetch_req_valid,
  input  icache_pkg::fetch_req_t   fetch_req,
  output logic                     fetch_req_ready,
  output logic                     fetch_resp_valid,
  output icache_pkg::fetch_resp_t  fetch_resp,
  input  logic                     fetch_resp_ready,
  input  logic                     flush,
  input  logic                     mem_wr_valid,
  input  icache_pkg::mem_wr_t      mem_wr,
  output logic [31:0]              hit_count,
  output logic [31:0]              miss_count
);

  wire                      mem_ar_valid;
  wire icache_pkg::mem_ar_t mem_ar;
  wire                      mem_ar_ready;
  wire                      mem_r_valid;
  wire icache_pkg::mem_r_t  mem_r;
  wire                      mem_r_ready;
  wire                      hit_evt;
  wire                      miss_evt;

  icache icache_i (
    .clk              (clk),
    .rstn             (rstn),
    .fetch_req_valid  (fetch_req_valid),
    .fetch_req        (fetch_req),
    .fetch_req_ready  (fetch_req_ready),
    .fetch_resp_valid (fetch_resp_valid),
    .fetch_resp       (fetch_resp),
    .fetch_resp_ready (fetch_resp_ready),
    .flush            (flush),
    .mem_ar_valid     (mem_ar_valid),
    .mem_ar           (mem_ar),
    .mem_ar_ready     (mem_ar_ready),
    .mem_r_valid      (mem_r_valid),
    .mem_r            (mem_r),
    .mem_r_ready      (mem_r_ready),
    .hit_evt          (hit_evt),
    .miss_evt         (miss_evt)
  );

  burst_ram burst_ram_i (
    .clk          (clk),
    .rstn         (rstn),
    .mem_ar_valid (mem_ar_valid),
    .mem_ar       (mem_ar),
    .mem_ar_ready (mem_ar_ready),
    .mem_r_valid  (mem_r_valid),
    .mem_r        (mem_r),
    .mem_r_ready  (mem_r_ready),
    .mem_wr_valid (mem_wr_valid),
    .mem_wr       (mem_wr)
  );

  icache_perf icache_perf_i (
    .clk        (clk),
    .rstn       (rstn),
    .hit_evt    (hit_evt),
    .miss_evt   (miss_evt),
    .hit_count  (hit_count),
    .miss_count (miss_count)
  );

endmodule

`default_nettype wire

//--- bench/icache_sys_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "icache_settings.svh"

module icache_sys_tb;

  localparam int LINES  = 1 << `ICACHE_INDEX_W;
  localparam int WORDS  = `ICACHE_WORDS;
  localparam int DEPTH  = 1 << `MEM_ADDR_W;
  localparam int TAG_W  = `ICACHE_TAG_W;
  localparam int WOFF_W = `ICACHE_OFFSET_W - 2;
  localparam int N_REQ  = 1 + 3 + 2 + 2 + 300; // fetches over all tests

  typedef logic [`MEM_ADDR_W-1:0] widx_t;
  typedef logic [WOFF_W-1:0]      woff_t;
  typedef logic [`ICACHE_INDEX_W-1:0] lidx_t;

  logic clk;
  logic rstn;
  logic fetch_req_valid;
  logic fetch_req_ready;
  logic fetch_resp_valid;
  logic fetch_resp_ready;
  logic flush;
  logic mem_wr_valid;
  logic [31:0] hit_count;
  logic [31:0] miss_count;
  icache_pkg::fetch_req_t  fetch_req;
  icache_pkg::fetch_resp_t fetch_resp;
  icache_pkg::mem_wr_t     mem_wr;

  // reference model state
  logic [31:0]      ref_mem [DEPTH];
  logic [31:0]      ref_line [LINES][WORDS];
  logic [TAG_W-1:0] ref_tag [LINES];
  logic [LINES-1:0] ref_valid = '0;
  logic [31:0]      exp_q [$];

  int  exp_hits = 0;
  int  exp_misses = 0;
  int  errors = 0;
  int  n_checks = 0;
  int  n_sent = 0;
  int  n_resp = 0;
  bit  bp_en = 1'b0;

  icache_sys_top dut_i (
    .clk              (clk),
    .rstn             (rstn),
    .fetch_req_valid  (fetch_req_valid),
    .fetch_req        (fetch_req),
    .fetch_req_ready  (fetch_req_ready),
    .fetch_resp_valid (fetch_resp_valid),
    .fetch_resp       (fetch_resp),
    .fetch_resp_ready (fetch_resp_ready),
    .flush            (flush),
    .mem_wr_valid     (mem_wr_valid),
    .mem_wr           (mem_wr),
    .hit_count        (hit_count),
    .miss_count       (miss_count)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // expected word and hit flag by the direct-mapped rule
  function automatic logic [31:0] ref_fetch(input logic [31:0] addr, output logic hit);
    lidx_t idx;
    woff_t wrd;
    idx = addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    wrd = addr[2 +: WOFF_W];
    hit = ref_valid[idx] && (ref_tag[idx] == addr[31 -: TAG_W]);
    if (hit) return ref_line[idx][wrd];
    return ref_mem[addr[`MEM_ADDR_W+1:2]];
  endfunction

  task automatic install_line(input logic [31:0] addr);
    lidx_t idx;
    widx_t widx;
    woff_t wrd;
    idx  = addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    widx = {addr[`MEM_ADDR_W+1:`ICACHE_OFFSET_W], {WOFF_W{1'b0}}};
    wrd  = '0;
    ref_valid[idx] = 1'b1;
    ref_tag[idx]   = addr[31 -: TAG_W];
    repeat (WORDS) begin
      ref_line[idx][wrd] = ref_mem[widx];
      widx = widx + widx_t'(1);
      wrd  = wrd + woff_t'(1);
    end
  endtask

  // caller drops mem_wr_valid after the last write
  task automatic mem_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk);
    mem_wr_valid <= 1'b1;
    mem_wr.addr  <= addr;
    mem_wr.data  <= data;
    ref_mem[addr[`MEM_ADDR_W+1:2]] = data;
  endtask

  task automatic fetch(input logic [31:0] addr);
    logic hit;
    logic [31:0] word;
    word = ref_fetch(addr, hit);
    if (hit) begin
      exp_hits++;
    end else begin
      exp_misses++;
      install_line(addr);
    end
    exp_q.push_back(word);
    @(posedge clk);
    fetch_req_valid <= 1'b1;
    fetch_req.addr  <= addr;
    @(negedge clk);
    while (!fetch_req_ready) @(negedge clk);
    @(posedge clk); // handshake edge
    fetch_req_valid <= 1'b0;
    n_sent++;
  endtask

  task automatic wait_idle();
    @(negedge clk);
    while (exp_q.size() != 0 || !fetch_req_ready) @(negedge clk);
    repeat (2) @(negedge clk); // counters lag the event by a cycle
  endtask

  task automatic flush_cache();
    @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    ref_valid = '0;
  endtask

  task automatic check_counts();
    check("hit_count", hit_count, exp_hits);
    check("miss_count", miss_count, exp_misses);
  endtask

  task automatic test_done(input string name, input int err_before);
    $display("%s: %s", name, (errors == err_before) ? "ok" : "mismatch");
  endtask

  // response checker
  initial begin
    forever begin
      @(negedge clk);
      if (rstn && fetch_resp_valid && fetch_resp_ready) begin
        n_resp++;
        if (exp_q.size() == 0) begin
          $display("Error at %0t: response arrived with no fetch outstanding", $time);
          errors++;
        end else begin
          check("fetch_resp.data", fetch_resp.data, exp_q.pop_front());
        end
      end
    end
  end

  // fetch_resp_ready back-pressure
  initial begin
    fetch_resp_ready = 1'b0;
    forever begin
      @(posedge clk);
      fetch_resp_ready <= bp_en ? ($urandom % 3 != 0) : 1'b1;
    end
  end

  initial begin
    repeat (N_REQ * (`MEM_LATENCY + WORDS + 20)) @(posedge clk);
    $display("Error: watchdog expired, fetch traffic stalled");
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    int err0;
    int w;
    logic [31:0] a0;
    logic [31:0] a1;
    logic [31:0] addr;
    void'($urandom(42));
    rstn            = 1'b0;
    fetch_req_valid = 1'b0;
    fetch_req       = '0;
    flush           = 1'b0;
    mem_wr_valid    = 1'b0;
    mem_wr          = '0;
    repeat (10) @(posedge clk);
    rstn <= 1'b1;

    err0 = errors;
    @(negedge clk);
    check("fetch_req_ready", fetch_req_ready, 32'd1);
    check("fetch_resp_valid", fetch_resp_valid, 32'd0);
    check("hit_count", hit_count, 32'd0);
    check("miss_count", miss_count, 32'd0);

    addr = '0;
    repeat (DEPTH) begin
      mem_write(addr, $urandom());
      addr = addr + 32'd4;
    end
    @(posedge clk);
    mem_wr_valid <= 1'b0;

    a0 = 32'h0000_0128; // line 2 word 2
    fetch(a0);
    wait_idle();
    check("miss_count", miss_count, 32'd1);
    check_counts();
    test_done("cold miss", err0);

    err0 = errors;
    for (w = 0; w < WORDS; w++) begin
      if (w != 2) fetch({a0[31:`ICACHE_OFFSET_W], 4'h0} + w * 4);
    end
    wait_idle();
    check("hit_count", hit_count, 32'd3);
    check_counts();
    test_done("line hits", err0);

    err0 = errors;
    a1 = a0 + 32'h40; // same index with a new tag
    fetch(a1);
    fetch(a0);
    wait_idle();
    check_counts();
    test_done("conflict", err0);

    err0 = errors;
    mem_write(a0, ~ref_mem[a0[`MEM_ADDR_W+1:2]]);
    @(posedge clk);
    mem_wr_valid <= 1'b0;
    fetch(a0); // stale hit
    wait_idle();
    flush_cache();
    fetch(a0);
    wait_idle();
    check_counts();
    test_done("flush", err0);

    err0 = errors;
    bp_en = 1'b1;
    repeat (300) fetch($urandom() & 32'h0000_00fc);
    wait_idle();
    bp_en = 1'b0;
    check_counts();
    check("response count", n_resp, n_sent);
    test_done("random", err0);

    $display("tests 5, checks %0d, errors %0d", n_checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- icache_sys.f
+incdir+rtl
rtl/icache_pkg.sv
rtl/icache_perf.sv
rtl/burst_ram.sv
rtl/icache.sv
rtl/icache_sys_top.sv
bench/icache_sys_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f icache_sys.f --top-module icache_sys_tb \
  -o icache_sys_sim \
  && ./obj_dir/icache_sys_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Result: PASSED" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
